//--- verilog/alu_pkg.sv
package alu_pkg;

    localparam int ALU_W = 32;
    localparam int CNT_W = 5;   // shift count 1..16

    typedef enum logic [4:0] {
        // arithmetic
        OP_ADD,
        OP_ADC,
        OP_SUB,
        OP_SBC,
        OP_CP,
        // logic
        OP_AND,
        OP_OR,
        OP_XOR,
        // single bit
        OP_BIT,
        OP_SET,
        OP_RES,
        OP_CHG,
        OP_TSET,
        // carry flag
        OP_LDCF,
        OP_ANDCF,
        OP_ORCF,
        OP_XORCF,
        OP_SCF,
        OP_RCF,
        OP_CCF,
        OP_ZCF,
        // shifts and rotates, one bit per clock
        OP_RLC,
        OP_RRC,
        OP_RL,
        OP_RR,
        OP_SLA,
        OP_SRA,
        OP_SLL,
        OP_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        WORD = 2'd1,
        LONG = 2'd2
    } alu_width_e;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;
        logic n;
        logic c;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e           op;
        alu_width_e        width;
        logic [ALU_W-1:0]  op0;     // destination
        logic [ALU_W-1:0]  op1;     // source
    } alu_req_t;

    typedef struct packed {
        logic [ALU_W-1:0]  value;
        alu_flags_t        flags;
        logic              wr_value;
    } alu_res_t;

    function automatic logic is_shift_op(alu_op_e op);
        return op inside {OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SLL, OP_SRL};
    endfunction

    function automatic logic [ALU_W-1:0] width_mask(alu_width_e w);
        case (w)
            BYTE:    return 32'h0000_00ff;
            WORD:    return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic int unsigned width_msb(alu_width_e w);
        case (w)
            BYTE:    return 7;
            WORD:    return 15;
            default: return 31;
        endcase
    endfunction

    // P/V as parity, only the low byte or word counts
    function automatic logic even_parity(logic [ALU_W-1:0] v, alu_width_e w);
        return (w == BYTE) ? ~^v[7:0] : ~^v[15:0];
    endfunction

endpackage

//--- verilog/alu_arith.sv
`timescale 1ns/1ps

module alu_arith (
    input  alu_pkg::alu_req_t   req,
    input  alu_pkg::alu_flags_t flags_in,
    output alu_pkg::alu_res_t   res
);

    logic [alu_pkg::ALU_W-1:0] a;
    logic [alu_pkg::ALU_W-1:0] b;
    logic [alu_pkg::ALU_W-1:0] sum;
    logic [alu_pkg::ALU_W-1:0] mask;
    logic                      sub;
    logic                      cin;
    logic                      c3;
    logic                      c7;
    logic                      c15;
    logic                      c31;
    logic                      cout;
    logic                      a_s;
    logic                      b_s;
    logic                      r_s;
    int unsigned               msb;

    always_comb begin
        a    = req.op0;
        b    = req.op1;
        mask = alu_pkg::width_mask(req.width);
        msb  = alu_pkg::width_msb(req.width);
        sub  = req.op inside {alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP};
        cin  = (req.op == alu_pkg::OP_ADC || req.op == alu_pkg::OP_SBC) && flags_in.c;

        // segmented so the nibble, byte and word carries come out directly
        if (sub) begin
            {c3,  sum[3:0]}   = {1'b0, a[3:0]}   - {1'b0, b[3:0]}   - {4'd0, cin};
            {c7,  sum[7:4]}   = {1'b0, a[7:4]}   - {1'b0, b[7:4]}   - {4'd0, c3};
            {c15, sum[15:8]}  = {1'b0, a[15:8]}  - {1'b0, b[15:8]}  - {8'd0, c7};
            {c31, sum[31:16]} = {1'b0, a[31:16]} - {1'b0, b[31:16]} - {16'd0, c15};
        end else begin
            {c3,  sum[3:0]}   = {1'b0, a[3:0]}   + {1'b0, b[3:0]}   + {4'd0, cin};
            {c7,  sum[7:4]}   = {1'b0, a[7:4]}   + {1'b0, b[7:4]}   + {4'd0, c3};
            {c15, sum[15:8]}  = {1'b0, a[15:8]}  + {1'b0, b[15:8]}  + {8'd0, c7};
            {c31, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b[31:16]} + {16'd0, c15};
        end

        case (req.width)
            alu_pkg::BYTE: cout = c7;
            alu_pkg::WORD: cout = c15;
            default:       cout = c31;
        endcase

        a_s = a[msb];
        b_s = b[msb];
        r_s = sum[msb];

        res.value    = (sum & mask) | (a & ~mask);  // upper bits kept from op0
        res.flags.s  = r_s;
        res.flags.z  = (sum & mask) == '0;
        res.flags.h  = c3;
        // signed overflow at the operand width
        res.flags.v  = sub ? ((a_s ^ b_s) & (r_s ^ a_s)) : (~(a_s ^ b_s) & (r_s ^ a_s));
        res.flags.n  = sub;
        res.flags.c  = cout;
        res.wr_value = req.op != alu_pkg::OP_CP;    // compare only sets flags
    end

endmodule

//--- verilog/alu_logic.sv
`timescale 1ns/1ps

module alu_logic (
    input  alu_pkg::alu_req_t   req,
    input  alu_pkg::alu_flags_t flags_in,
    output alu_pkg::alu_res_t   res
);

    logic [alu_pkg::ALU_W-1:0] mask;
    logic [alu_pkg::ALU_W-1:0] lres;
    logic [3:0]                idx;
    logic                      bit_old;
    int unsigned               msb;

    always_comb begin
        mask    = alu_pkg::width_mask(req.width);
        msb     = alu_pkg::width_msb(req.width);
        idx     = req.op1[3:0];     // bit number
        bit_old = req.op0[idx];

        case (req.op)
            alu_pkg::OP_AND: lres = req.op0 & req.op1;
            alu_pkg::OP_OR:  lres = req.op0 | req.op1;
            default:         lres = req.op0 ^ req.op1;
        endcase

        // flags untouched unless an op says otherwise
        res.value    = req.op0;
        res.flags    = flags_in;
        res.wr_value = 1'b0;

        case (req.op)
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
                res.value    = (lres & mask) | (req.op0 & ~mask);
                res.flags.s  = lres[msb];
                res.flags.z  = (lres & mask) == '0;
                res.flags.h  = req.op == alu_pkg::OP_AND;
                res.flags.v  = alu_pkg::even_parity(lres, req.width);
                res.flags.n  = 1'b0;
                res.flags.c  = 1'b0;
                res.wr_value = 1'b1;
            end
            alu_pkg::OP_BIT: begin
                res.flags.z = ~bit_old;
                res.flags.h = 1'b1;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_SET: begin
                res.value[idx] = 1'b1;
                res.wr_value   = 1'b1;
            end
            alu_pkg::OP_RES: begin
                res.value[idx] = 1'b0;
                res.wr_value   = 1'b1;
            end
            alu_pkg::OP_CHG: begin
                res.value[idx] = ~bit_old;
                res.wr_value   = 1'b1;
            end
            alu_pkg::OP_TSET: begin     // test as BIT, then set
                res.value[idx] = 1'b1;
                res.wr_value   = 1'b1;
                res.flags.z    = ~bit_old;
                res.flags.h    = 1'b1;
                res.flags.n    = 1'b0;
            end
            alu_pkg::OP_LDCF: begin
                res.flags.c = bit_old;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_ANDCF: begin
                res.flags.c = flags_in.c & bit_old;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_ORCF: begin
                res.flags.c = flags_in.c | bit_old;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_XORCF: begin
                res.flags.c = flags_in.c ^ bit_old;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_SCF, alu_pkg::OP_RCF: begin
                res.flags.c = req.op == alu_pkg::OP_SCF;
                res.flags.h = 1'b0;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_CCF: begin
                res.flags.c = ~flags_in.c;
                res.flags.n = 1'b0;
            end
            alu_pkg::OP_ZCF: begin
                res.flags.c = ~flags_in.z;
                res.flags.n = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/alu_shift.sv
`timescale 1ns/1ps

module alu_shift (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  alu_pkg::alu_req_t   req,
    input  logic                carry_in,
    output alu_pkg::alu_res_t   res,
    output logic                step_done,
    output logic                busy
);

    logic [alu_pkg::ALU_W-1:0] val_q;
    logic [alu_pkg::ALU_W-1:0] src;
    logic [alu_pkg::ALU_W-1:0] step;
    logic [alu_pkg::ALU_W-1:0] mask;
    logic                      cy_q;
    logic                      cy_src;
    logic                      in_bit;
    logic                      out_bit;
    logic                      run;
    logic                      active_q;
    alu_pkg::alu_op_e          op_q;
    alu_pkg::alu_op_e          op;
    alu_pkg::alu_width_e       width_q;
    alu_pkg::alu_width_e       width;
    logic [alu_pkg::CNT_W-1:0] cnt_q;
    logic [alu_pkg::CNT_W-1:0] remain;
    int unsigned               msb;

    assign run = load || active_q;

    always_comb begin
        // first step works straight off the request
        src    = load ? req.op0 : val_q;
        cy_src = load ? carry_in : cy_q;
        op     = load ? req.op : op_q;
        width  = load ? req.width : width_q;
        remain = load ? {req.op1[3:0] == 4'd0, req.op1[3:0]} : cnt_q;  // 0 means 16
        mask   = alu_pkg::width_mask(width);
        msb    = alu_pkg::width_msb(width);

        case (op)
            alu_pkg::OP_RLC, alu_pkg::OP_RL, alu_pkg::OP_SLA, alu_pkg::OP_SLL: begin
                out_bit = src[msb];
                if (op == alu_pkg::OP_RLC)
                    in_bit = src[msb];
                else
                    in_bit = (op == alu_pkg::OP_RL) && cy_src;
                step = {src[alu_pkg::ALU_W-2:0], in_bit};
            end
            default: begin              // right shifts
                out_bit = src[0];
                case (op)
                    alu_pkg::OP_RRC: in_bit = src[0];
                    alu_pkg::OP_RR:  in_bit = cy_src;
                    alu_pkg::OP_SRA: in_bit = src[msb];    // sign repeats
                    default:         in_bit = 1'b0;
                endcase
                step      = (src & mask) >> 1;
                step[msb] = in_bit;
            end
        endcase

        res.value    = (step & mask) | (src & ~mask);
        res.flags.s  = res.value[msb];
        res.flags.z  = (res.value & mask) == '0;
        res.flags.h  = 1'b0;
        res.flags.v  = alu_pkg::even_parity(res.value, width);
        res.flags.n  = 1'b0;
        res.flags.c  = out_bit;     // last bit out
        res.wr_value = 1'b1;
    end

    assign step_done = run && remain == 1;
    assign busy      = run && remain != 1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (run) begin
            active_q <= remain != 1;
            cnt_q    <= remain - 1'b1;
        end
    end

    // working copy of the operation in flight
    always_ff @(posedge clk) begin
        if (run) begin
            val_q   <= res.value;
            cy_q    <= out_bit;
            op_q    <= op;
            width_q <= width;
        end
    end

endmodule

//--- verilog/alu_ctrl.sv
`timescale 1ns/1ps

module alu_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  alu_pkg::alu_req_t         req,
    input  alu_pkg::alu_res_t         arith_res,
    input  alu_pkg::alu_res_t         logic_res,
    input  alu_pkg::alu_res_t         shift_res,
    input  logic                      shift_done,
    input  logic                      shift_busy,
    output logic                      shift_load,
    output alu_pkg::alu_req_t         cur_req,
    output alu_pkg::alu_flags_t       flags,
    output logic [alu_pkg::ALU_W-1:0] result,
    output logic                      busy,
    output logic                      done
);

    logic              accept;
    logic              pend_q;      // cur_req executes this cycle
    logic              is_shift;
    logic              is_arith;
    logic              complete;
    alu_pkg::alu_res_t sel;

    assign busy   = shift_busy;
    assign accept = start && !busy;

    assign is_shift = alu_pkg::is_shift_op(cur_req.op);
    assign is_arith = cur_req.op inside {alu_pkg::OP_ADD, alu_pkg::OP_ADC,
                                         alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP};

    assign shift_load = pend_q && is_shift;
    assign complete   = (pend_q && !is_shift) || shift_done;

    always_comb begin
        if (is_shift)
            sel = shift_res;
        else if (is_arith)
            sel = arith_res;
        else
            sel = logic_res;
    end

    always_ff @(posedge clk) begin
        if (accept)
            cur_req <= req;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_q <= 1'b0;
            done   <= 1'b0;
            flags  <= '0;
            result <= '0;
        end else begin
            pend_q <= accept;
            done   <= complete;
            if (complete) begin
                flags <= sel.flags;
                if (sel.wr_value)
                    result <= sel.value;
            end
        end
    end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  alu_pkg::alu_req_t         req,
    output logic [alu_pkg::ALU_W-1:0] result,
    output alu_pkg::alu_flags_t       flags,
    output logic                      busy,
    output logic                      done
);

    alu_pkg::alu_req_t cur_req;
    alu_pkg::alu_res_t arith_res;
    alu_pkg::alu_res_t logic_res;
    alu_pkg::alu_res_t shift_res;
    logic              shift_done;
    logic              shift_busy;
    logic              shift_load;

    alu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .req        (req),
        .arith_res  (arith_res),
        .logic_res  (logic_res),
        .shift_res  (shift_res),
        .shift_done (shift_done),
        .shift_busy (shift_busy),
        .shift_load (shift_load),
        .cur_req    (cur_req),
        .flags      (flags),
        .result     (result),
        .busy       (busy),
        .done       (done)
    );

    alu_arith u_arith (
        .req      (cur_req),
        .flags_in (flags),
        .res      (arith_res)
    );

    alu_logic u_logic (
        .req      (cur_req),
        .flags_in (flags),
        .res      (logic_res)
    );

    alu_shift u_shift (
        .clk       (clk),
        .rst       (rst),
        .load      (shift_load),
        .req       (cur_req),
        .carry_in  (flags.c),
        .res       (shift_res),
        .step_done (shift_done),
        .busy      (shift_busy)
    );

endmodule

//--- testbench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- testbench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

    localparam int DONE_TIMEOUT = 24;

    localparam alu_pkg::alu_op_e ARITH_OPS [5] = '{alu_pkg::OP_ADD, alu_pkg::OP_ADC,
        alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP};
    localparam alu_pkg::alu_op_e LOGIC_OPS [3] = '{alu_pkg::OP_AND, alu_pkg::OP_OR,
        alu_pkg::OP_XOR};
    localparam alu_pkg::alu_op_e BIT_OPS [5] = '{alu_pkg::OP_BIT, alu_pkg::OP_SET,
        alu_pkg::OP_RES, alu_pkg::OP_CHG, alu_pkg::OP_TSET};
    localparam alu_pkg::alu_op_e CARRY_OPS [8] = '{alu_pkg::OP_LDCF, alu_pkg::OP_ANDCF,
        alu_pkg::OP_ORCF, alu_pkg::OP_XORCF, alu_pkg::OP_SCF, alu_pkg::OP_RCF,
        alu_pkg::OP_CCF, alu_pkg::OP_ZCF};
    localparam alu_pkg::alu_op_e SHIFT_OPS [8] = '{alu_pkg::OP_RLC, alu_pkg::OP_RRC,
        alu_pkg::OP_RL, alu_pkg::OP_RR, alu_pkg::OP_SLA, alu_pkg::OP_SRA,
        alu_pkg::OP_SLL, alu_pkg::OP_SRL};

    logic                clk;
    logic                rst;
    logic                start;
    alu_pkg::alu_req_t   req;
    logic [31:0]         result;
    alu_pkg::alu_flags_t flags;
    logic                busy;
    logic                done;

    logic [31:0]         exp_result;    // reference model state
    alu_pkg::alu_flags_t exp_flags;

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    alu_top dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .result (result),
        .flags  (flags),
        .busy   (busy),
        .done   (done)
    );

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    done_single_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else fail_now($sformatf("Mismatch at %0t: done high for two cycles", $time));
    done_not_busy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else fail_now($sformatf("Mismatch at %0t: done while busy", $time));

    function automatic alu_pkg::alu_width_e width_of(int i);
        case (i)
            0:       return alu_pkg::BYTE;
            1:       return alu_pkg::WORD;
            default: return alu_pkg::LONG;
        endcase
    endfunction

    function automatic alu_pkg::alu_width_e random_width();
        return width_of($urandom % 3);
    endfunction

    function automatic int width_bits(alu_pkg::alu_width_e w);
        case (w)
            alu_pkg::BYTE: return 8;
            alu_pkg::WORD: return 16;
            default:       return 32;
        endcase
    endfunction

    function automatic logic [31:0] low_ones(int n);
        logic [63:0] one;
        one = 64'd1 << n;
        return 32'(one - 64'd1);
    endfunction

    // true when the low n bits hold an even number of ones
    function automatic logic parity_even(logic [31:0] v, int n);
        int ones;
        ones = 0;
        for (int i = 0; i < n; i++)
            if (v[i])
                ones++;
        return (ones % 2) == 0;
    endfunction

    // applies one request to exp_result and exp_flags
    task automatic predict(input alu_pkg::alu_req_t r, output int cycles);
        int                  n;
        int                  msb;
        int                  k;
        logic [31:0]         m;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         val;
        logic [63:0]         full;
        logic [4:0]          nib;
        logic                cin;
        logic                sub;
        logic                cy;
        logic                in_bit;
        logic                old;
        logic [3:0]          idx;
        alu_pkg::alu_flags_t f;

        n      = width_bits(r.width);
        msb    = n - 1;
        m      = low_ones(n);
        a      = r.op0 & m;
        b      = r.op1 & m;
        idx    = r.op1[3:0];
        old    = r.op0[idx];
        f      = exp_flags;
        cycles = 1;

        case (r.op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBC,
            alu_pkg::OP_CP: begin
                sub = r.op inside {alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP};
                cin = (r.op inside {alu_pkg::OP_ADC, alu_pkg::OP_SBC}) && f.c;
                if (sub) begin
                    full = {32'd0, a} - {32'd0, b} - 64'(cin);
                    nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin);
                end else begin
                    full = {32'd0, a} + {32'd0, b} + 64'(cin);
                    nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
                end
                val = full[31:0] & m;
                f.s = val[msb];
                f.z = val == 32'd0;
                f.h = nib[4];
                if (sub)
                    f.v = (a[msb] != b[msb]) && (val[msb] != a[msb]);
                else
                    f.v = (a[msb] == b[msb]) && (val[msb] != a[msb]);
                f.n = sub;
                f.c = full[n];      // carry or borrow out of the width
                if (r.op != alu_pkg::OP_CP)
                    exp_result = val | (r.op0 & ~m);
            end
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
                if (r.op == alu_pkg::OP_AND)
                    val = r.op0 & r.op1 & m;
                else if (r.op == alu_pkg::OP_OR)
                    val = (r.op0 | r.op1) & m;
                else
                    val = (r.op0 ^ r.op1) & m;
                f.s = val[msb];
                f.z = val == 32'd0;
                f.h = r.op == alu_pkg::OP_AND;
                f.v = parity_even(val, (n == 8) ? 8 : 16);
                f.n = 1'b0;
                f.c = 1'b0;
                exp_result = val | (r.op0 & ~m);
            end
            alu_pkg::OP_BIT, alu_pkg::OP_TSET: begin
                f.z = !old;
                f.h = 1'b1;
                f.n = 1'b0;
                if (r.op == alu_pkg::OP_TSET)
                    exp_result = r.op0 | (32'd1 << idx);
            end
            alu_pkg::OP_SET: exp_result = r.op0 | (32'd1 << idx);
            alu_pkg::OP_RES: exp_result = r.op0 & ~(32'd1 << idx);
            alu_pkg::OP_CHG: exp_result = r.op0 ^ (32'd1 << idx);
            alu_pkg::OP_LDCF, alu_pkg::OP_ANDCF, alu_pkg::OP_ORCF, alu_pkg::OP_XORCF,
            alu_pkg::OP_SCF, alu_pkg::OP_RCF, alu_pkg::OP_CCF, alu_pkg::OP_ZCF: begin
                case (r.op)
                    alu_pkg::OP_LDCF:  f.c = old;
                    alu_pkg::OP_ANDCF: f.c = f.c & old;
                    alu_pkg::OP_ORCF:  f.c = f.c | old;
                    alu_pkg::OP_XORCF: f.c = f.c ^ old;
                    alu_pkg::OP_SCF:   f.c = 1'b1;
                    alu_pkg::OP_RCF:   f.c = 1'b0;
                    alu_pkg::OP_CCF:   f.c = !f.c;
                    default:           f.c = !f.z;
                endcase
                if (r.op inside {alu_pkg::OP_SCF, alu_pkg::OP_RCF})
                    f.h = 1'b0;
                f.n = 1'b0;
            end
            default: begin          // shifts one bit per step
                k      = (idx == 4'd0) ? 16 : int'(idx);
                cycles = k;
                val    = r.op0;
                cy     = f.c;
                for (int i = 0; i < k; i++) begin
                    if (r.op inside {alu_pkg::OP_RLC, alu_pkg::OP_RL, alu_pkg::OP_SLA,
                                     alu_pkg::OP_SLL}) begin
                        if (r.op == alu_pkg::OP_RLC)
                            in_bit = val[msb];
                        else
                            in_bit = (r.op == alu_pkg::OP_RL) && cy;
                        cy  = val[msb];
                        val = ((val << 1) | 32'(in_bit)) & m;
                    end else begin
                        case (r.op)
                            alu_pkg::OP_RRC: in_bit = val[0];
                            alu_pkg::OP_RR:  in_bit = cy;
                            alu_pkg::OP_SRA: in_bit = val[msb];
                            default:         in_bit = 1'b0;
                        endcase
                        cy  = val[0];
                        val = ((val & m) >> 1) | (32'(in_bit) << msb);
                    end
                    val = val | (r.op0 & ~m);   // bits above the width stay
                end
                f.s = val[msb];
                f.z = (val & m) == 32'd0;
                f.h = 1'b0;
                f.v = parity_even(val, (n == 8) ? 8 : 16);
                f.n = 1'b0;
                f.c = cy;
                exp_result = val;
            end
        endcase
        exp_flags = f;
    endtask

    // runs one request to done and pokes a second start while busy if intrude is set
    task automatic run_op(input alu_pkg::alu_op_e op, input alu_pkg::alu_width_e w,
                          input logic [31:0] op0, input logic [31:0] op1,
                          input logic intrude);
        alu_pkg::alu_req_t r;
        int                exp_cycles;
        int                cycles;
        int                busy_cycles;

        r.op    = op;
        r.width = w;
        r.op0   = op0;
        r.op1   = op1;
        predict(r, exp_cycles);
        req   = r;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (!done)
            else fail_now($sformatf("Mismatch at %0t: done still high at acceptance", $time));
        cycles      = 0;
        busy_cycles = busy ? 1 : 0;
        while (!done) begin
            if (cycles > DONE_TIMEOUT)
                fail_now($sformatf("Timeout: no done for %s within %0d cycles",
                                   op.name(), DONE_TIMEOUT));
            if (intrude && cycles == 1) begin
                assert (busy)
                    else fail_now($sformatf("Mismatch at %0t: busy low mid shift", $time));
                req.op  = alu_pkg::OP_XOR;
                req.op0 = $urandom;
                req.op1 = $urandom;
                start   = 1'b1;
            end
            if (intrude && cycles == 2)
                start = 1'b0;
            @(posedge clk);
            #1;
            cycles++;
            if (!done && busy)
                busy_cycles++;
        end
        assert (cycles == exp_cycles)
            else fail_now($sformatf("Mismatch at %0t: %s done after %0d cycles, expected %0d",
                                    $time, op.name(), cycles, exp_cycles));
        assert (busy_cycles == exp_cycles - 1)
            else fail_now($sformatf("Mismatch at %0t: %s busy for %0d cycles, expected %0d",
                                    $time, op.name(), busy_cycles, exp_cycles - 1));
        assert (result == exp_result)
            else fail_now($sformatf("Mismatch at %0t: %s result %h, expected %h",
                                    $time, op.name(), result, exp_result));
        assert (flags == exp_flags)
            else fail_now($sformatf("Mismatch at %0t: %s flags %b, expected %b",
                                    $time, op.name(), flags, exp_flags));
        if (intrude) begin
            repeat (4) begin
                @(posedge clk);
                #1;
                assert (!done && result == exp_result)
                    else fail_now($sformatf("Mismatch at %0t: start while busy was accepted",
                                            $time));
            end
        end
    endtask

    initial begin
        int n;

        start      = 1'b0;
        req        = '0;
        exp_result = '0;
        exp_flags  = '0;
        void'($urandom(32'h4d5c));

        n = 0;
        do begin
            if (n > 10)
                fail_now("Timeout: reset was never released");
            @(negedge clk);
            n++;
        end while (rst);
        @(posedge clk);
        #1;

        assert (!busy && !done && result == '0 && flags == '0)
            else fail_now($sformatf("Mismatch at %0t: outputs not cleared by reset", $time));

        foreach (ARITH_OPS[i])
            for (int wi = 0; wi < 3; wi++)
                repeat (4)
                    run_op(ARITH_OPS[i], width_of(wi), $urandom, $urandom, 1'b0);
        run_op(alu_pkg::OP_ADD, alu_pkg::BYTE, 32'h1234_567f, 32'h0000_0081, 1'b0);
        run_op(alu_pkg::OP_SUB, alu_pkg::WORD, 32'hcafe_0000, 32'h0000_0001, 1'b0);
        run_op(alu_pkg::OP_CP, alu_pkg::LONG, 32'h8000_0000, 32'h0000_0001, 1'b0);

        foreach (LOGIC_OPS[i])
            for (int wi = 0; wi < 3; wi++)
                repeat (4)
                    run_op(LOGIC_OPS[i], width_of(wi), $urandom, $urandom, 1'b0);

        // carry and zero chain through the sequence
        repeat (4) begin
            foreach (BIT_OPS[i])
                run_op(BIT_OPS[i], random_width(), $urandom, $urandom, 1'b0);
            foreach (CARRY_OPS[i])
                run_op(CARRY_OPS[i], random_width(), $urandom, $urandom, 1'b0);
        end

        foreach (SHIFT_OPS[i]) begin
            for (int wi = 0; wi < 3; wi++)
                run_op(SHIFT_OPS[i], width_of(wi), $urandom, $urandom, 1'b0);
            run_op(SHIFT_OPS[i], random_width(), $urandom, 32'h0000_0000, 1'b0);   // 16
            run_op(SHIFT_OPS[i], random_width(), $urandom, 32'h0000_0001, 1'b0);
        end

        run_op(alu_pkg::OP_RL, alu_pkg::LONG, $urandom, 32'h0000_0008, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- list.f
verilog/alu_pkg.sv
verilog/alu_arith.sv
verilog/alu_logic.sv
verilog/alu_shift.sv
verilog/alu_ctrl.sv
verilog/alu_top.sv
testbench/clk_gen.sv
testbench/alu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
